// ==== stream_merger.f ====
+incdir+common
common/merge_pkg.sv
hw/bitonic_merger/compare_swap.sv
hw/bitonic_merger/bitonic_merge_network.sv
hw/block_fifo.sv
hw/merge_control.sv
hw/stream_merger_top.sv
sim/stream_merger_props.sv
sim/stream_merger_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := stream_merger_tb
FILELIST  := stream_merger.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard common/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# The simulator is rebuilt only when a source, a header or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/stream_merger_tb.sv ====
// Directed testbench for the two-way stream merge unit.
// Source models send sorted blocks under input credits, a sink grants output
// credits, and each output block is compared with the sorted input records.
`timescale 1ns/1ps
`include "merge_defs.svh"

module stream_merger_tb;
   import merge_pkg::*;

   localparam int RESET_CYCLES = 16;

   logic   i_clk;
   logic   i_rst;
   logic   i_a_valid;
   block_t i_a_block;
   logic   o_a_credit;
   logic   i_b_valid;
   block_t i_b_block;
   logic   o_b_credit;
   logic   i_out_credit;
   logic   o_out_valid;
   block_t o_out_block;

   block_t a_q[$];
   block_t b_q[$];
   block_t exp_q[$];
   block_t got_q[$];
   key_t   ka[$];
   key_t   kb[$];

   int   a_sent = 0;
   int   b_sent = 0;
   int   a_returned = 0;
   int   b_returned = 0;
   int   n_granted = 0;
   int   n_received = 0;
   int   credit_gap = 0;
   int   gap_left = 0;
   logic grant_on = 1'b0;
   int   cycle_budget = 0;
   int   cycle_count = 0;
   int   n_errors = 0;

   stream_merger_top i_stream_merger_top (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_a_valid    (i_a_valid),
      .i_a_block    (i_a_block),
      .o_a_credit   (o_a_credit),
      .i_b_valid    (i_b_valid),
      .i_b_block    (i_b_block),
      .o_b_credit   (o_b_credit),
      .i_out_credit (i_out_credit),
      .o_out_valid  (o_out_valid),
      .o_out_block  (o_out_block)
   );

   initial i_clk = 1'b0;
   always #20 i_clk = ~i_clk;

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped at the first error.");
   endtask

   task automatic check_block(input string name, input block_t exp, input block_t got);
      if (got !== exp) begin
         n_errors++;
         stop_run($sformatf("Mismatch %s: expected %h, got %h", name, exp, got));
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         n_errors++;
         stop_run($sformatf("Mismatch %s: expected %h, got %h", name, exp, got));
      end
   endtask

   task automatic check_count(input string name, input int exp, input int got);
      if (got != exp) begin
         n_errors++;
         stop_run($sformatf("Mismatch %s: expected %0h, got %0h", name, exp, got));
      end
   endtask

   // Credit returns and output blocks are sampled mid-cycle, where the credit rule is checked.
   always @(negedge i_clk) begin
      if (!i_rst) begin
         if (o_a_credit) begin
            a_returned++;
         end
         if (o_b_credit) begin
            b_returned++;
         end
         if (o_out_valid) begin
            got_q.push_back(o_out_block);
            n_received++;
            if (n_received > n_granted) begin
               stop_run("The DUT sent an output block without a granted credit.");
            end
         end
      end
   end

   // The sink keeps at most four credits outstanding, with an optional gap between grants.
   always @(posedge i_clk) begin
      #2;
      if (!grant_on) begin
         i_out_credit = 1'b0;
         gap_left = 0;
      end else if (n_granted - n_received < 4 && gap_left == 0) begin
         i_out_credit = 1'b1;
         n_granted++;
         gap_left = credit_gap;
      end else begin
         i_out_credit = 1'b0;
         if (gap_left > 0) begin
            gap_left--;
         end
      end
   end

   always @(posedge i_clk) begin
      cycle_count++;
      if (cycle_count > RESET_CYCLES + cycle_budget + 200) begin
         stop_run($sformatf("Timeout: the merged stream was not complete after %0d cycles.",
                            cycle_count));
      end
   end

   task automatic feed_a();
      while (a_q.size() > 0) begin
         @(posedge i_clk);
         #2;
         if (`MG_FIFO_DEPTH + a_returned - a_sent > 0) begin
            i_a_valid = 1'b1;
            i_a_block = a_q.pop_front();
            a_sent++;
         end else begin
            i_a_valid = 1'b0;
         end
      end
      @(posedge i_clk);
      #2;
      i_a_valid = 1'b0;
   endtask

   task automatic feed_b();
      while (b_q.size() > 0) begin
         @(posedge i_clk);
         #2;
         if (`MG_FIFO_DEPTH + b_returned - b_sent > 0) begin
            i_b_valid = 1'b1;
            i_b_block = b_q.pop_front();
            b_sent++;
         end else begin
            i_b_valid = 1'b0;
         end
      end
      @(posedge i_clk);
      #2;
      i_b_valid = 1'b0;
   endtask

   // Turns the key lists into input blocks and appends the sorted expected stream.
   task automatic add_job();
      record_t    all[$];
      record_t    r;
      block_t     blk;
      logic [1:0] lane;
      blk = '0;
      for (int i = 0; i < ka.size(); i++) begin
         r.key = ka[i];
         r.payload = ka[i] ^ 16'ha5c3;
         all.push_back(r);
         lane = 2'(i % 4);
         blk.rec[lane] = r;
         blk.last = (i == ka.size() - 1);
         if (lane == 2'd3) begin
            a_q.push_back(blk);
         end
      end
      for (int i = 0; i < kb.size(); i++) begin
         r.key = kb[i];
         r.payload = kb[i] ^ 16'h3c5a;
         all.push_back(r);
         lane = 2'(i % 4);
         blk.rec[lane] = r;
         blk.last = (i == kb.size() - 1);
         if (lane == 2'd3) begin
            b_q.push_back(blk);
         end
      end
      for (int i = 1; i < all.size(); i++) begin
         for (int j = i; j > 0 && all[j-1].key > all[j].key; j--) begin
            r = all[j];
            all[j] = all[j-1];
            all[j-1] = r;
         end
      end
      for (int i = 0; i < all.size(); i++) begin
         lane = 2'(i % 4);
         blk.rec[lane] = all[i];
         blk.last = (i == all.size() - 1);
         if (lane == 2'd3) begin
            exp_q.push_back(blk);
         end
      end
      ka.delete();
      kb.delete();
   endtask

   task automatic run_jobs(input int gap);
      int n_exp;
      n_exp = exp_q.size();
      cycle_budget += n_exp * 8 * (gap + 1) + 50;
      credit_gap = gap;
      grant_on = 1'b1;
      fork
         feed_a();
         feed_b();
         while (got_q.size() < n_exp) begin
            @(negedge i_clk);
         end
      join
      grant_on = 1'b0;
      // A few idle cycles show any surplus output block.
      repeat (8) @(posedge i_clk);
      check_count("output block count", n_exp, got_q.size());
      for (int i = 0; i < n_exp; i++) begin
         check_bit("o_out_block.last", exp_q[i].last, got_q[i].last);
         check_block("o_out_block", exp_q[i], got_q[i]);
      end
      check_count("o_a_credit pulses", a_sent, a_returned);
      check_count("o_b_credit pulses", b_sent, b_returned);
      exp_q.delete();
      got_q.delete();
   endtask

   task automatic test_interleaved();
      for (int i = 0; i < 12; i++) begin
         ka.push_back(key_t'(4 * i + 1));
         kb.push_back(key_t'(4 * i + 3));
      end
      add_job();
      run_jobs(0);
   endtask

   task automatic test_uneven();
      for (int i = 0; i < 4; i++) begin
         ka.push_back(key_t'(103 + 50 * i));
      end
      for (int i = 0; i < 20; i++) begin
         kb.push_front(key_t'(290 - 10 * i));
      end
      add_job();
      run_jobs(0);
   endtask

   task automatic test_uneven_swapped();
      for (int i = 0; i < 20; i++) begin
         ka.push_back(key_t'(200 + 10 * i));
      end
      for (int i = 0; i < 4; i++) begin
         kb.push_back(key_t'(7 + 113 * i));
      end
      add_job();
      run_jobs(0);
   endtask

   task automatic test_throttle();
      for (int i = 0; i < 8; i++) begin
         ka.push_back(key_t'(1000 + 6 * i));
         kb.push_back(key_t'(1001 + 4 * i));
      end
      add_job();
      run_jobs(30);
   endtask

   // Three jobs share the input queues and run without a pause between them.
   task automatic test_random_jobs();
      int la;
      int lb;
      int key;
      for (int j = 0; j < 3; j++) begin
         la = 1 + $urandom % 6;
         lb = 1 + $urandom % 6;
         key = 0;
         for (int i = 0; i < 4 * (la + lb); i++) begin
            key += 1 + $urandom % 200;
            if (ka.size() == 4 * la) begin
               kb.push_back(key_t'(key));
            end else if (kb.size() == 4 * lb) begin
               ka.push_back(key_t'(key));
            end else if ($urandom % 2 == 0) begin
               ka.push_back(key_t'(key));
            end else begin
               kb.push_back(key_t'(key));
            end
         end
         add_job();
      end
      run_jobs(0);
   endtask

   initial begin
      void'($urandom(34));
      i_rst = 1'b1;
      i_a_valid = 1'b0;
      i_a_block = '0;
      i_b_valid = 1'b0;
      i_b_block = '0;
      i_out_credit = 1'b0;
      repeat (RESET_CYCLES) @(posedge i_clk);
      #2;
      i_rst = 1'b0;
      test_interleaved();
      test_uneven();
      test_uneven_swapped();
      test_throttle();
      test_random_jobs();
      if (n_errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== sim/stream_merger_props.sv ====
// Assertions on the credit and valid rules of the stream merge unit.
// Attached to the top level by the bind statement at the end of this file.
`timescale 1ns/1ps

module stream_merger_props (
   input logic               i_clk,
   input logic               i_rst,
   input logic               i_out_valid,
   input logic               i_a_credit,
   input logic               i_b_credit,
   input logic               i_issue,
   input merge_pkg::credit_t i_cred
);

   // A merge spends one output credit, so none may start with the count at zero.
   a_issue_needs_credit: assert property (@(posedge i_clk) disable iff (i_rst)
      i_issue |-> i_cred != '0)
      else $error("Merge issued while the output credit count was zero");

   // Only one merge is in flight, so results are at least four cycles apart.
   a_result_spacing: assert property (@(posedge i_clk) disable iff (i_rst)
      i_out_valid |-> !$past(i_out_valid, 1) && !$past(i_out_valid, 2) &&
                      !$past(i_out_valid, 3))
      else $error("Network result valid again within three cycles");

   a_quiet_after_reset: assert property (@(posedge i_clk)
      $fell(i_rst) |-> !i_out_valid && !i_a_credit && !i_b_credit && i_cred == '0)
      else $error("Valid, credit pulse or credit count not cleared by reset");

endmodule

bind stream_merger_top stream_merger_props u_props (
   .i_clk       (i_clk),
   .i_rst       (i_rst),
   .i_out_valid (o_out_valid),
   .i_a_credit  (o_a_credit),
   .i_b_credit  (o_b_credit),
   .i_issue     (issue),
   .i_cred      (u_control.cred_q)
);

// ==== hw/stream_merger_top.sv ====
// Top level of the streaming two-way merge unit.
// Two credit-controlled input FIFOs feed the controller, which drives the
// bitonic merge network; the network's lower half is the output stream.
`timescale 1ns/1ps

module stream_merger_top (
   input  logic              i_clk,
   input  logic              i_rst,
   input  logic              i_a_valid,
   input  merge_pkg::block_t i_a_block,
   output logic              o_a_credit,
   input  logic              i_b_valid,
   input  merge_pkg::block_t i_b_block,
   output logic              o_b_credit,
   input  logic              i_out_credit,
   output logic              o_out_valid,
   output merge_pkg::block_t o_out_block
);
   import merge_pkg::*;

   block_t a_head;
   block_t b_head;
   block_t fb_block;
   block_t sel_block;
   block_t res_lo;
   block_t res_hi;
   logic   a_empty;
   logic   b_empty;
   logic   a_pop;
   logic   b_pop;
   logic   issue;
   logic   issue_last;
   logic   res_last;

   block_fifo u_fifo_a (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_valid  (i_a_valid),
      .i_block  (i_a_block),
      .i_pop    (a_pop),
      .o_block  (a_head),
      .o_empty  (a_empty),
      .o_credit (o_a_credit)
   );

   block_fifo u_fifo_b (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_valid  (i_b_valid),
      .i_block  (i_b_block),
      .i_pop    (b_pop),
      .o_block  (b_head),
      .o_empty  (b_empty),
      .o_credit (o_b_credit)
   );

   merge_control u_control (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_a_block    (a_head),
      .i_a_empty    (a_empty),
      .i_b_block    (b_head),
      .i_b_empty    (b_empty),
      .o_a_pop      (a_pop),
      .o_b_pop      (b_pop),
      .i_out_credit (i_out_credit),
      .i_res_valid  (o_out_valid),
      .i_res_hi     (res_hi),
      .o_issue      (issue),
      .o_issue_last (issue_last),
      .o_fb_block   (fb_block),
      .o_sel_block  (sel_block)
   );

   bitonic_merge_network u_network (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_valid    (issue),
      .i_last     (issue_last),
      .i_blk_a    (fb_block),
      .i_blk_b    (sel_block),
      .o_valid    (o_out_valid),
      .o_last     (res_last),
      .o_lo_block (res_lo),
      .o_hi_block (res_hi)
   );

   // The last flag of the merged stream comes from the flush merge.
   always_comb begin
      o_out_block      = res_lo;
      o_out_block.last = res_last;
   end

endmodule

// ==== hw/merge_control.sv ====
// Controller of the two-way merge: chooses the next input block, keeps the
// feedback block, counts output credits and issues one merge at a time.
// A job ends with a flush merge against an all-ones sentinel block.
`timescale 1ns/1ps

module merge_control (
   input  logic              i_clk,
   input  logic              i_rst,
   input  merge_pkg::block_t i_a_block,
   input  logic              i_a_empty,
   input  merge_pkg::block_t i_b_block,
   input  logic              i_b_empty,
   output logic              o_a_pop,
   output logic              o_b_pop,
   input  logic              i_out_credit,
   input  logic              i_res_valid,
   input  merge_pkg::block_t i_res_hi,
   output logic              o_issue,
   output logic              o_issue_last,
   output merge_pkg::block_t o_fb_block,
   output merge_pkg::block_t o_sel_block
);
   import merge_pkg::*;

   localparam block_t SENTINEL = '{rec: '1, last: 1'b0};

   ctrl_state_t state_q;
   ctrl_state_t state_d;
   block_t      fb_q;
   block_t      head;
   credit_t     cred_q;
   logic        a_done_q;
   logic        b_done_q;
   logic        flush_q;
   logic        can_sel;
   logic        pick_a;
   logic        take;
   logic        have_cred;

   assign have_cred = (cred_q != '0);

   // Each stream must show a head block or be finished before a choice is made.
   assign can_sel = (!i_a_empty || a_done_q) && (!i_b_empty || b_done_q) &&
                    !(a_done_q && b_done_q);
   // Ties go to A.
   assign pick_a = !a_done_q &&
                   (b_done_q || i_a_block.rec[0].key <= i_b_block.rec[0].key);
   assign head = pick_a ? i_a_block : i_b_block;

   always_comb begin
      state_d      = state_q;
      take         = 1'b0;
      o_issue      = 1'b0;
      o_issue_last = 1'b0;
      o_sel_block  = head;
      case (state_q)
         ST_IDLE: begin
            if (!i_a_empty || !i_b_empty) begin
               state_d = ST_LOAD;
            end
         end
         ST_LOAD: begin
            if (can_sel) begin
               take    = 1'b1;
               state_d = ST_RUN;
            end
         end
         ST_RUN: begin
            if (a_done_q && b_done_q) begin
               state_d = ST_FLUSH;
            end else if (can_sel && have_cred) begin
               take    = 1'b1;
               o_issue = 1'b1;
               state_d = ST_WAIT_RESULT;
            end
         end
         ST_FLUSH: begin
            o_sel_block = SENTINEL;
            if (have_cred) begin
               o_issue      = 1'b1;
               o_issue_last = 1'b1;
               state_d      = ST_WAIT_RESULT;
            end
         end
         ST_WAIT_RESULT: begin
            if (i_res_valid) begin
               state_d = flush_q ? ST_IDLE : ST_RUN;
            end
         end
         default: state_d = ST_IDLE;
      endcase
   end

   assign o_a_pop    = take && pick_a;
   assign o_b_pop    = take && !pick_a;
   assign o_fb_block = fb_q;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state_q  <= ST_IDLE;
         a_done_q <= 1'b0;
         b_done_q <= 1'b0;
         flush_q  <= 1'b0;
         cred_q   <= '0;
      end else begin
         state_q <= state_d;
         if (state_q == ST_IDLE) begin
            a_done_q <= 1'b0;
            b_done_q <= 1'b0;
            flush_q  <= 1'b0;
         end
         if (o_a_pop && i_a_block.last) begin
            a_done_q <= 1'b1;
         end
         if (o_b_pop && i_b_block.last) begin
            b_done_q <= 1'b1;
         end
         if (o_issue_last) begin
            flush_q <= 1'b1;
         end
         if (i_out_credit && !o_issue) begin
            cred_q <= cred_q + 1'b1;
         end else if (!i_out_credit && o_issue) begin
            cred_q <= cred_q - 1'b1;
         end
      end
   end

   // The upper half of each merge result becomes the next feedback.
   always_ff @(posedge i_clk) begin
      if (take && state_q == ST_LOAD) begin
         fb_q <= head;
      end else if (state_q == ST_WAIT_RESULT && i_res_valid) begin
         fb_q <= i_res_hi;
      end
   end

endmodule

// ==== hw/block_fifo.sv ====
// Input block FIFO of the merge unit with credit return.
// The head block is visible without a read cycle; o_credit pulses the
// cycle after each pop and gives the sender one credit back.
`timescale 1ns/1ps
`include "merge_defs.svh"

module block_fifo (
   input  logic              i_clk,
   input  logic              i_rst,
   input  logic              i_valid,
   input  merge_pkg::block_t i_block,
   input  logic              i_pop,
   output merge_pkg::block_t o_block,
   output logic              o_empty,
   output logic              o_credit
);
   import merge_pkg::*;

   localparam int IDX_W = $clog2(`MG_FIFO_DEPTH);

   block_t mem [`MG_FIFO_DEPTH];

   // One extra pointer bit tells full from empty.
   logic [IDX_W:0] wr_ptr;
   logic [IDX_W:0] rd_ptr;
   logic           do_pop;

   assign o_empty = (wr_ptr == rd_ptr);
   assign do_pop  = i_pop && !o_empty;
   assign o_block = mem[rd_ptr[IDX_W-1:0]];

   always_ff @(posedge i_clk) begin
      if (i_valid) begin
         mem[wr_ptr[IDX_W-1:0]] <= i_block;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         o_credit <= 1'b0;
      end else begin
         o_credit <= do_pop;
         if (i_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

endmodule

// ==== hw/bitonic_merger/bitonic_merge_network.sv ====
// Three-stage bitonic merger for two ascending four-record blocks.
// The eight sorted records leave as a lower and an upper block, with valid
// and last delayed alongside by the network latency.
`timescale 1ns/1ps
`include "merge_defs.svh"

module bitonic_merge_network (
   input  logic              i_clk,
   input  logic              i_rst,
   input  logic              i_valid,
   input  logic              i_last,
   input  merge_pkg::block_t i_blk_a,
   input  merge_pkg::block_t i_blk_b,
   output logic              o_valid,
   output logic              o_last,
   output merge_pkg::block_t o_lo_block,
   output merge_pkg::block_t o_hi_block
);
   import merge_pkg::*;

   localparam int LANES = 2 * `MG_BLOCK_N;

   record_t st1 [LANES];
   record_t st2 [LANES];
   record_t st3 [LANES];

   logic [`MG_NET_LAT-1:0] vld_sr;
   logic [`MG_NET_LAT-1:0] last_sr;

   genvar i;
   genvar h;

   // Stage one pairs A ascending with B reversed. Both halves come out
   // bitonic and every lower lane is below every upper lane.
   for (i = 0; i < 4; i++) begin : g_stage1
      compare_swap u_cs (
         .i_clk (i_clk),
         .i_rst (i_rst),
         .i_lo  (i_blk_a.rec[i]),
         .i_hi  (i_blk_b.rec[3-i]),
         .o_lo  (st1[i]),
         .o_hi  (st1[4+i])
      );
   end

   // Half-cleaners at distance 2, then at distance 1, within each half.
   for (h = 0; h < 2; h++) begin : g_half
      for (i = 0; i < 2; i++) begin : g_lane
         compare_swap u_cs2 (
            .i_clk (i_clk),
            .i_rst (i_rst),
            .i_lo  (st1[4*h+i]),
            .i_hi  (st1[4*h+i+2]),
            .o_lo  (st2[4*h+i]),
            .o_hi  (st2[4*h+i+2])
         );
         compare_swap u_cs3 (
            .i_clk (i_clk),
            .i_rst (i_rst),
            .i_lo  (st2[4*h+2*i]),
            .i_hi  (st2[4*h+2*i+1]),
            .o_lo  (st3[4*h+2*i]),
            .o_hi  (st3[4*h+2*i+1])
         );
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         vld_sr  <= '0;
         last_sr <= '0;
      end else begin
         vld_sr  <= {vld_sr[`MG_NET_LAT-2:0], i_valid};
         last_sr <= {last_sr[`MG_NET_LAT-2:0], i_last};
      end
   end

   assign o_valid = vld_sr[`MG_NET_LAT-1];
   assign o_last  = last_sr[`MG_NET_LAT-1];

   always_comb begin
      for (int k = 0; k < `MG_BLOCK_N; k++) begin
         o_lo_block.rec[k] = st3[k];
         o_hi_block.rec[k] = st3[`MG_BLOCK_N+k];
      end
      o_lo_block.last = 1'b0;
      o_hi_block.last = 1'b0;
   end

endmodule

// ==== hw/bitonic_merger/compare_swap.sv ====
// Registered compare-and-swap cell of the bitonic merger.
// o_lo gets the record with the smaller key one cycle after the inputs.
`timescale 1ns/1ps

module compare_swap (
   input  logic              i_clk,
   input  logic              i_rst,
   input  merge_pkg::record_t i_lo,
   input  merge_pkg::record_t i_hi,
   output merge_pkg::record_t o_lo,
   output merge_pkg::record_t o_hi
);

   // Equal keys keep their lanes.
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_lo <= '0;
         o_hi <= '0;
      end else if (i_lo.key > i_hi.key) begin
         o_lo <= i_hi;
         o_hi <= i_lo;
      end else begin
         o_lo <= i_lo;
         o_hi <= i_hi;
      end
   end

endmodule

// ==== common/merge_pkg.sv ====
// Shared types of the merge unit: records, blocks, credits and controller states.
// Modules import this package inside their bodies.
`include "merge_defs.svh"

package merge_pkg;

   typedef logic [`MG_KEY_W-1:0] key_t;
   typedef logic [`MG_DATA_W-1:0] payload_t;
   typedef logic [`MG_CREDIT_W-1:0] credit_t;

   // Key sits in the upper bits so a record compares by key first.
   typedef struct packed {
      key_t     key;
      payload_t payload;
   } record_t;

   // Record 0 holds the smallest key of the block.
   typedef struct packed {
      record_t [`MG_BLOCK_N-1:0] rec;
      logic                      last;
   } block_t;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_LOAD,
      ST_RUN,
      ST_FLUSH,
      ST_WAIT_RESULT
   } ctrl_state_t;

endpackage

// ==== common/merge_defs.svh ====
// Build-time constants for the two-way record merge unit.
// Include wherever a width, a depth or the network latency is needed.
`ifndef MERGE_DEFS_SVH
`define MERGE_DEFS_SVH

// Record fields.
`define MG_KEY_W 16
`define MG_DATA_W 16

// Records per block, sorted ascending within the block.
`define MG_BLOCK_N 4

// Input FIFO depth in blocks, also the initial credit count of a source.
`define MG_FIFO_DEPTH 4
`define MG_CREDIT_W 4

// Cycles from a merge issue to the valid result.
`define MG_NET_LAT 3

`endif
